// File: logic/i2c_bus_pkg.sv
// i2c bus package: line-level widths, line indices and glitch filter constants
package i2c_bus_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////
  typedef logic [15:0] presc_t;     // scl prescale value and divider count
  typedef logic [13:0] filt_cnt_t;  // filter sample divider

  //////////////////////////////////////////////////////////////////////
  // glitch filter
  //////////////////////////////////////////////////////////////////////
  // prescale >> 2 gives 16 filter samples per scl period
  localparam int FILTER_SHIFT = 2;
  localparam int SYNC_STAGES  = 2;  // capture flops ahead of the filter
  localparam int FILTER_TAPS  = 3;  // majority window, 2 of 3

  //////////////////////////////////////////////////////////////////////
  // line indices
  //////////////////////////////////////////////////////////////////////
  localparam int LINE_SCL = 0;
  localparam int LINE_SDA = 1;
  localparam int LINE_CNT = 2;  // scl and sda

endpackage

// File: logic/i2c_cmd_pkg.sv
// i2c command package: bit command codes and the bit FSM state encoding
package i2c_cmd_pkg;

  // one-bit commands from the byte side
  typedef enum logic [3:0] {
    CMD_NOP   = 4'b0000,
    CMD_START = 4'b0001,
    CMD_STOP  = 4'b0010,
    CMD_WRITE = 4'b0100,
    CMD_READ  = 4'b1000
  } cmd_t;

  // one-hot bit states, idle is all zeros
  typedef enum logic [17:0] {
    ST_IDLE = 18'h00000,
    START_A = 18'h00001,
    START_B = 18'h00002,
    START_C = 18'h00004,
    START_D = 18'h00008,
    START_E = 18'h00010,
    STOP_A  = 18'h00020,
    STOP_B  = 18'h00040,
    STOP_C  = 18'h00080,
    STOP_D  = 18'h00100,
    RD_A    = 18'h00200,
    RD_B    = 18'h00400,
    RD_C    = 18'h00800,
    RD_D    = 18'h01000,
    WR_A    = 18'h02000,
    WR_B    = 18'h04000,
    WR_C    = 18'h08000,
    WR_D    = 18'h10000
  } bit_state_t;

endpackage

// File: logic/i2c_line_if.sv
// i2c line interface: filtered scl/sda levels and their one-cycle delayed copies
`timescale 1ns/1ns

interface i2c_line_if;

  // indexed by LINE_SCL / LINE_SDA
  logic [i2c_bus_pkg::LINE_CNT-1:0] line_lvl;  // filtered level
  logic [i2c_bus_pkg::LINE_CNT-1:0] line_dly;  // filtered level, one cycle late

  // each filter drives its own slot
  modport filt (output line_lvl, output line_dly);

  // monitor, timer and fsm only look
  modport mon (input line_lvl, input line_dly);

endinterface

// File: logic/i2c_filter_tick.sv
// i2c filter tick: divides the prescale down to the glitch filter sample strobe
`timescale 1ns/1ns

module i2c_filter_tick (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                ena_i,      // core enable
  input  i2c_bus_pkg::presc_t clk_cnt_i,  // scl prescale value
  output logic                smp_stb_o   // filter sample strobe
);

  i2c_bus_pkg::filt_cnt_t cnt_q;  // sample divider

  // count down, reload on zero, parked at zero while disabled
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (!ena_i) begin
      cnt_q <= '0;
    end else if (cnt_q == '0) begin
      cnt_q <= i2c_bus_pkg::filt_cnt_t'(clk_cnt_i >> i2c_bus_pkg::FILTER_SHIFT);  // 16x bus rate
    end else begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign smp_stb_o = (cnt_q == '0);  // sample on terminal count

endmodule

// File: logic/i2c_line_filter.sv
// i2c line filter: synchronizer, 2-of-3 glitch filter and delayed copy of one bus line
`timescale 1ns/1ns

module i2c_line_filter #(
  parameter int LINE_IDX = 0  // slot in the line interface
) (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    line_i,     // raw bus line
  input  logic    smp_stb_i,  // filter sample strobe
  i2c_line_if.filt lines
);

  logic [i2c_bus_pkg::SYNC_STAGES-1:0] sync_q;  // metastability capture
  logic [i2c_bus_pkg::FILTER_TAPS-1:0] win_q;   // sample window
  logic                                lvl_q;   // filtered level
  logic                                dly_q;   // filtered level, delayed

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q <= '0;
      win_q  <= '1;  // bus idles high
      lvl_q  <= 1'b1;
      dly_q  <= 1'b1;
    end else begin
      sync_q <= {sync_q[i2c_bus_pkg::SYNC_STAGES-2:0], line_i};
      if (smp_stb_i) begin
        win_q <= {win_q[i2c_bus_pkg::FILTER_TAPS-2:0], sync_q[i2c_bus_pkg::SYNC_STAGES-1]};
      end
      // majority of the three taps
      lvl_q <= (win_q[2] & win_q[1]) | (win_q[1] & win_q[0]) | (win_q[2] & win_q[0]);
      dly_q <= lvl_q;  // for edge detection downstream
    end
  end

  assign lines.line_lvl[LINE_IDX] = lvl_q;
  assign lines.line_dly[LINE_IDX] = dly_q;

endmodule

// File: logic/i2c_bus_monitor.sv
// i2c bus monitor: start/stop detection, busy flag and read bit capture
`timescale 1ns/1ns

module i2c_bus_monitor (
  input  logic    clk_i,
  input  logic    rst_n_i,
  i2c_line_if.mon lines,
  output logic    busy_o,     // bus owned by some master
  output logic    dat_o,      // last bit sampled on scl rise
  output logic    sto_cond_o  // stop seen on the bus
);

  logic scl_lvl;
  logic scl_dly;
  logic sda_lvl;
  logic sda_dly;
  logic sta_q;  // start condition, registered
  logic sto_q;  // stop condition, registered

  assign scl_lvl = lines.line_lvl[i2c_bus_pkg::LINE_SCL];
  assign scl_dly = lines.line_dly[i2c_bus_pkg::LINE_SCL];
  assign sda_lvl = lines.line_lvl[i2c_bus_pkg::LINE_SDA];
  assign sda_dly = lines.line_dly[i2c_bus_pkg::LINE_SDA];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sta_q  <= 1'b0;
      sto_q  <= 1'b0;
      busy_o <= 1'b0;
      dat_o  <= 1'b1;
    end else begin
      sta_q  <= ~sda_lvl & sda_dly & scl_lvl;  // sda falls, scl high
      sto_q  <= sda_lvl & ~sda_dly & scl_lvl;  // sda rises, scl high
      busy_o <= (sta_q | busy_o) & ~sto_q;     // start sets, stop clears
      if (scl_lvl && !scl_dly) begin
        dat_o <= sda_lvl;  // read bit on scl rise
      end
    end
  end

  assign sto_cond_o = sto_q;

endmodule

// File: logic/i2c_scl_timer.sv
// i2c scl timer: scl phase clock enable with slave stretching and clock sync
`timescale 1ns/1ns

module i2c_scl_timer (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                ena_i,      // core enable
  input  i2c_bus_pkg::presc_t clk_cnt_i,  // phase length minus one
  input  logic                scl_dir_i,  // 1 = this master releases scl
  i2c_line_if.mon             lines,
  output logic                clk_en_o    // one phase step
);

  logic                scl_lvl;
  logic                scl_dly;
  logic                scl_dir_q;   // scl_dir_i one cycle late
  logic                slv_wait_q;  // slave holds scl low
  logic                scl_sync;    // another master pulled scl low
  i2c_bus_pkg::presc_t cnt_q;

  assign scl_lvl = lines.line_lvl[i2c_bus_pkg::LINE_SCL];
  assign scl_dly = lines.line_dly[i2c_bus_pkg::LINE_SCL];

  // released by us but falling on the bus, restart low phase
  assign scl_sync = scl_dly & ~scl_lvl & scl_dir_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      scl_dir_q  <= 1'b1;
      slv_wait_q <= 1'b0;
      cnt_q      <= '0;
      clk_en_o   <= 1'b1;
    end else begin
      scl_dir_q  <= scl_dir_i;
      // just released scl and it is still low, wait until it rises
      slv_wait_q <= (scl_dir_i & ~scl_dir_q & ~scl_lvl) | (slv_wait_q & ~scl_lvl);
      if (cnt_q == '0 || !ena_i || scl_sync) begin
        cnt_q    <= clk_cnt_i;  // reload and step
        clk_en_o <= 1'b1;
      end else begin
        cnt_q    <= slv_wait_q ? cnt_q : cnt_q - 1'b1;  // frozen while stretched
        clk_en_o <= 1'b0;
      end
    end
  end

endmodule

// File: logic/i2c_bit_fsm.sv
// i2c bit FSM: command phases, open-drain directions and arbitration lost detection
`timescale 1ns/1ns

module i2c_bit_fsm (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  i2c_cmd_pkg::cmd_t  cmd_i,       // held until cmd_ack_o
  input  logic               dat_i,       // write bit
  input  logic               clk_en_i,    // phase step
  input  logic               sto_cond_i,  // stop seen on the bus
  i2c_line_if.mon            lines,
  output logic               cmd_ack_o,   // one cycle, command done
  output logic               al_o,        // arbitration lost
  output logic               scl_dir_o,   // 0 pulls scl low
  output logic               sda_dir_o    // 0 pulls sda low
);

  i2c_cmd_pkg::bit_state_t state_q;
  logic                    sda_lvl;
  logic                    sda_chk_q;   // compare sda against what we drive
  logic                    cmd_stop_q;  // current command is a stop

  assign sda_lvl = lines.line_lvl[i2c_bus_pkg::LINE_SDA];

  //////////////////////////////////////////////////////////////////////
  // arbitration
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cmd_stop_q <= 1'b0;
      al_o       <= 1'b0;
    end else begin
      if (clk_en_i) begin
        cmd_stop_q <= (cmd_i == i2c_cmd_pkg::CMD_STOP);
      end
      // released sda reads low, or a foreign stop mid-command
      al_o <= (sda_chk_q & ~sda_lvl & sda_dir_o) |
              ((state_q != i2c_cmd_pkg::ST_IDLE) & sto_cond_i & ~cmd_stop_q);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // phase sequencer
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= i2c_cmd_pkg::ST_IDLE;
      cmd_ack_o <= 1'b0;
      scl_dir_o <= 1'b1;
      sda_dir_o <= 1'b1;
      sda_chk_q <= 1'b0;
    end else if (al_o) begin  // lost the bus, let go of both lines
      state_q   <= i2c_cmd_pkg::ST_IDLE;
      cmd_ack_o <= 1'b0;
      scl_dir_o <= 1'b1;
      sda_dir_o <= 1'b1;
      sda_chk_q <= 1'b0;
    end else begin
      cmd_ack_o <= 1'b0;  // single cycle ack
      if (clk_en_i) begin
        sda_chk_q <= 1'b0;  // only checked in WR_C
        case (state_q)
          i2c_cmd_pkg::ST_IDLE: begin
            case (cmd_i)
              i2c_cmd_pkg::CMD_START: state_q <= i2c_cmd_pkg::START_A;
              i2c_cmd_pkg::CMD_STOP:  state_q <= i2c_cmd_pkg::STOP_A;
              i2c_cmd_pkg::CMD_WRITE: state_q <= i2c_cmd_pkg::WR_A;
              i2c_cmd_pkg::CMD_READ:  state_q <= i2c_cmd_pkg::RD_A;
              default:                state_q <= i2c_cmd_pkg::ST_IDLE;
            endcase
          end
          // start, also repeated start from scl low
          i2c_cmd_pkg::START_A: begin
            state_q   <= i2c_cmd_pkg::START_B;
            sda_dir_o <= 1'b1;  // sda up first
          end
          i2c_cmd_pkg::START_B: begin
            state_q   <= i2c_cmd_pkg::START_C;
            scl_dir_o <= 1'b1;
            sda_dir_o <= 1'b1;
          end
          i2c_cmd_pkg::START_C: begin
            state_q   <= i2c_cmd_pkg::START_D;
            scl_dir_o <= 1'b1;
            sda_dir_o <= 1'b0;  // the start edge
          end
          i2c_cmd_pkg::START_D: begin
            state_q   <= i2c_cmd_pkg::START_E;
            scl_dir_o <= 1'b1;  // hold time
            sda_dir_o <= 1'b0;
          end
          i2c_cmd_pkg::START_E: begin
            state_q   <= i2c_cmd_pkg::ST_IDLE;
            cmd_ack_o <= 1'b1;
            scl_dir_o <= 1'b0;
            sda_dir_o <= 1'b0;
          end
          // stop
          i2c_cmd_pkg::STOP_A: begin
            state_q   <= i2c_cmd_pkg::STOP_B;
            scl_dir_o <= 1'b0;
            sda_dir_o <= 1'b0;  // sda low under scl low
          end
          i2c_cmd_pkg::STOP_B: begin
            state_q   <= i2c_cmd_pkg::STOP_C;
            scl_dir_o <= 1'b1;
            sda_dir_o <= 1'b0;
          end
          i2c_cmd_pkg::STOP_C: begin
            state_q   <= i2c_cmd_pkg::STOP_D;
            scl_dir_o <= 1'b1;  // setup before the stop edge
            sda_dir_o <= 1'b0;
          end
          i2c_cmd_pkg::STOP_D: begin
            state_q   <= i2c_cmd_pkg::ST_IDLE;
            cmd_ack_o <= 1'b1;
            scl_dir_o <= 1'b1;
            sda_dir_o <= 1'b1;  // the stop edge
          end
          // read, sda left to the slave
          i2c_cmd_pkg::RD_A: begin
            state_q   <= i2c_cmd_pkg::RD_B;
            scl_dir_o <= 1'b0;
            sda_dir_o <= 1'b1;
          end
          i2c_cmd_pkg::RD_B: begin
            state_q   <= i2c_cmd_pkg::RD_C;
            scl_dir_o <= 1'b1;  // monitor samples on this rise
            sda_dir_o <= 1'b1;
          end
          i2c_cmd_pkg::RD_C: begin
            state_q   <= i2c_cmd_pkg::RD_D;
            scl_dir_o <= 1'b1;
            sda_dir_o <= 1'b1;
          end
          i2c_cmd_pkg::RD_D: begin
            state_q   <= i2c_cmd_pkg::ST_IDLE;
            cmd_ack_o <= 1'b1;
            scl_dir_o <= 1'b0;
            sda_dir_o <= 1'b1;
          end
          // write, data changes only while scl is low
          i2c_cmd_pkg::WR_A: begin
            state_q   <= i2c_cmd_pkg::WR_B;
            scl_dir_o <= 1'b0;
            sda_dir_o <= dat_i;
          end
          i2c_cmd_pkg::WR_B: begin
            state_q   <= i2c_cmd_pkg::WR_C;
            scl_dir_o <= 1'b1;
            sda_dir_o <= dat_i;  // lines settle before the check
          end
          i2c_cmd_pkg::WR_C: begin
            state_q   <= i2c_cmd_pkg::WR_D;
            scl_dir_o <= 1'b1;
            sda_dir_o <= dat_i;
            sda_chk_q <= 1'b1;  // arbitration window
          end
          i2c_cmd_pkg::WR_D: begin
            state_q   <= i2c_cmd_pkg::ST_IDLE;
            cmd_ack_o <= 1'b1;
            scl_dir_o <= 1'b0;
            sda_dir_o <= dat_i;
          end
          default: state_q <= i2c_cmd_pkg::ST_IDLE;  // recover from illegal code
        endcase
      end
    end
  end

endmodule

// File: logic/i2c_bit_ctrl.sv
// i2c bit controller top: turns one-bit commands into open-drain scl/sda activity
`timescale 1ns/1ns

module i2c_bit_ctrl (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                ena_i,      // core enable
  input  i2c_bus_pkg::presc_t clk_cnt_i,  // scl prescale value
  input  i2c_cmd_pkg::cmd_t   cmd_i,      // bit command
  input  logic                dat_i,      // write bit
  input  logic                scl_i,      // scl line in
  input  logic                sda_i,      // sda line in
  output logic                cmd_ack_o,  // command done
  output logic                busy_o,     // bus busy
  output logic                al_o,       // arbitration lost
  output logic                dat_o,      // read bit
  output logic                scl_dir_o,  // 0 pulls scl low
  output logic                sda_dir_o   // 0 pulls sda low
);

  logic [i2c_bus_pkg::LINE_CNT-1:0] raw_lines;
  logic                             smp_stb;
  logic                             clk_en;
  logic                             sto_cond;

  i2c_line_if u_lines ();

  assign raw_lines[i2c_bus_pkg::LINE_SCL] = scl_i;
  assign raw_lines[i2c_bus_pkg::LINE_SDA] = sda_i;

  //////////////////////////////////////////////////////////////////////
  // input conditioning
  //////////////////////////////////////////////////////////////////////
  i2c_filter_tick u_filter_tick (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .ena_i     (ena_i),
    .clk_cnt_i (clk_cnt_i),
    .smp_stb_o (smp_stb)
  );

  for (genvar gi = 0; gi < i2c_bus_pkg::LINE_CNT; gi++) begin : g_filt
    i2c_line_filter #(.LINE_IDX(gi)) u_line_filter (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .line_i    (raw_lines[gi]),
      .smp_stb_i (smp_stb),
      .lines     (u_lines.filt)
    );
  end

  //////////////////////////////////////////////////////////////////////
  // bus state, timing and sequencing
  //////////////////////////////////////////////////////////////////////
  i2c_bus_monitor u_bus_monitor (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .lines      (u_lines.mon),
    .busy_o     (busy_o),
    .dat_o      (dat_o),
    .sto_cond_o (sto_cond)
  );

  i2c_scl_timer u_scl_timer (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .ena_i     (ena_i),
    .clk_cnt_i (clk_cnt_i),
    .scl_dir_i (scl_dir_o),
    .lines     (u_lines.mon),
    .clk_en_o  (clk_en)
  );

  i2c_bit_fsm u_bit_fsm (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .cmd_i      (cmd_i),
    .dat_i      (dat_i),
    .clk_en_i   (clk_en),
    .sto_cond_i (sto_cond),
    .lines      (u_lines.mon),
    .cmd_ack_o  (cmd_ack_o),
    .al_o       (al_o),
    .scl_dir_o  (scl_dir_o),
    .sda_dir_o  (sda_dir_o)
  );

endmodule

// File: bench/tb_i2c_bit_ctrl.sv
// i2c bit controller testbench: wired-AND bus, slave model, command stimulus and checker
`timescale 1ns/1ns

module tb_i2c_bit_ctrl;

  localparam int ACK_TIMEOUT = 400;  // cycles, stretched commands included
  localparam int LVL_TIMEOUT = 100;  // cycles for busy and al
  localparam int CMD_GAP     = 8;    // idle cycles before each command

  logic                clk = 1'b0;
  logic                rst_n;
  logic                ena;
  i2c_bus_pkg::presc_t clk_cnt;
  i2c_cmd_pkg::cmd_t   cmd;
  logic                dat;
  logic                scl;
  logic                sda;
  logic                cmd_ack;
  logic                busy;
  logic                al;
  logic                dat_rd;
  logic                scl_dir;
  logic                sda_dir;

  logic                slv_scl_low;      // slave stretches scl
  logic                slv_sda_low;      // slave pulls sda
  i2c_cmd_pkg::cmd_t   last_cmd;         // command under test, kept past its ack
  logic [1:0]          ref_res;          // expected {al_o, dat_o}
  logic [31:0]         rnd;
  int                  seed;
  int                  idx;
  int                  base;             // ack count at command issue
  int                  ack_cnt     = 0;
  int                  chk_errors  = 0;
  int                  stim_errors = 0;
  int                  timeouts    = 0;

  // open drain, a released line reads high unless the slave pulls it
  assign scl = scl_dir & ~slv_scl_low;
  assign sda = sda_dir & ~slv_sda_low;

  always #5 clk = ~clk;  // 100 MHz

  i2c_bit_ctrl u_i2c_bit_ctrl (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .ena_i     (ena),
    .clk_cnt_i (clk_cnt),
    .cmd_i     (cmd),
    .dat_i     (dat),
    .scl_i     (scl),
    .sda_i     (sda),
    .cmd_ack_o (cmd_ack),
    .busy_o    (busy),
    .al_o      (al),
    .dat_o     (dat_rd),
    .scl_dir_o (scl_dir),
    .sda_dir_o (sda_dir)
  );

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////
  function automatic logic [1:0] expect_bit(input i2c_cmd_pkg::cmd_t c, input logic wbit,
                                            input logic pull);
    logic bus_bit;
    logic lost;
    bus_bit = ~pull;  // read: whatever the slave leaves on sda
    lost    = 1'b0;
    if (c == i2c_cmd_pkg::CMD_WRITE) begin
      bus_bit = wbit & ~pull;  // wired-AND of master and slave
      lost    = wbit & pull;   // released a 1, bus shows 0
    end
    return {lost, bus_bit};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // checker, samples between rising edges
  //////////////////////////////////////////////////////////////////////
  always @(negedge clk) begin
    if (rst_n) begin
      ref_res = expect_bit(last_cmd, dat, slv_sda_low);
      if (cmd_ack) begin
        ack_cnt++;
        if (last_cmd == i2c_cmd_pkg::CMD_READ || last_cmd == i2c_cmd_pkg::CMD_WRITE) begin
          assert (dat_rd == ref_res[0]) else begin
            $display("CHECK FAILED at %0t: dat_o = %b, expected %b", $time, dat_rd, ref_res[0]);
            chk_errors++;
          end
        end
      end
      if (al) begin  // only legal when the slave overrides a written 1
        assert (ref_res[1]) else begin
          $display("CHECK FAILED at %0t: al_o = %b, expected %b", $time, al, ref_res[1]);
          chk_errors++;
        end
      end
      // write data steady while scl is released
      if (cmd == i2c_cmd_pkg::CMD_WRITE && scl_dir) begin
        assert (sda_dir == dat) else begin
          $display("CHECK FAILED at %0t: sda_dir_o = %b, expected %b", $time, sda_dir, dat);
          chk_errors++;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus helpers
  //////////////////////////////////////////////////////////////////////
  task automatic issue_cmd(input i2c_cmd_pkg::cmd_t c, input logic wbit, input logic pull);
    repeat (CMD_GAP) @(posedge clk);
    cmd         <= c;
    dat         <= wbit;
    slv_sda_low <= pull;  // scl is low here, so no start or stop
    last_cmd    <= c;
    base         = ack_cnt;
  endtask

  task automatic wait_ack(input string what);
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!cmd_ack && waited < ACK_TIMEOUT);
    if (!cmd_ack) begin
      $display("timeout at %0t: %s was never acknowledged", $time, what);
      timeouts++;
    end
    @(posedge clk);
    cmd <= i2c_cmd_pkg::CMD_NOP;  // drop request before the next clk_en
  endtask

  task automatic wait_busy(input logic level);
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (busy != level && waited < LVL_TIMEOUT);
    if (busy != level) begin
      $display("timeout at %0t: busy_o never went to %b", $time, level);
      timeouts++;
    end
  endtask

  task automatic wait_lost();
    int waited;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!al && waited < ACK_TIMEOUT);
    if (!al) begin
      $display("timeout at %0t: arbitration loss was never flagged", $time);
      timeouts++;
    end
  endtask

  task automatic check_acks(input int expected);
    assert (ack_cnt - base == expected) else begin
      $display("CHECK FAILED at %0t: cmd_ack_o pulses = %0d, expected %0d",
               $time, ack_cnt - base, expected);
      stim_errors++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    seed        = 32'h66fa0fdc;
    rst_n       <= 1'b0;
    ena         <= 1'b1;
    clk_cnt     <= 16'd7;
    cmd         <= i2c_cmd_pkg::CMD_NOP;
    dat         <= 1'b0;
    slv_scl_low <= 1'b0;
    slv_sda_low <= 1'b0;
    last_cmd    <= i2c_cmd_pkg::CMD_NOP;
    repeat (2) @(posedge clk);
    @(negedge clk);
    assert ({cmd_ack, busy, al, scl_dir, sda_dir, dat_rd} == 6'b000111) else begin
      $display(
        "CHECK FAILED at %0t: {cmd_ack_o,busy_o,al_o,scl_dir_o,sda_dir_o,dat_o} = %b, expected %b",
        $time, {cmd_ack, busy, al, scl_dir, sda_dir, dat_rd}, 6'b000111);
      stim_errors++;
    end
    @(posedge clk);
    rst_n <= 1'b1;  // third rising edge

    // start then stop, busy follows the bus
    issue_cmd(i2c_cmd_pkg::CMD_START, 1'b0, 1'b0);
    wait_ack("START");
    wait_busy(1'b1);
    check_acks(1);
    issue_cmd(i2c_cmd_pkg::CMD_STOP, 1'b0, 1'b0);
    wait_ack("STOP");
    wait_busy(1'b0);
    check_acks(1);

    // random write bits
    issue_cmd(i2c_cmd_pkg::CMD_START, 1'b0, 1'b0);
    wait_ack("START");
    for (idx = 0; idx < 20; idx++) begin
      rnd = $random(seed);
      issue_cmd(i2c_cmd_pkg::CMD_WRITE, rnd[0], 1'b0);
      wait_ack("WRITE");
    end

    // slave drives a random bit for each read
    for (idx = 0; idx < 20; idx++) begin
      rnd = $random(seed);
      issue_cmd(i2c_cmd_pkg::CMD_READ, 1'b0, ~rnd[0]);
      wait_ack("READ");
    end

    // slave grabs scl while low and holds it
    rnd = $random(seed);
    issue_cmd(i2c_cmd_pkg::CMD_WRITE, rnd[0], 1'b0);
    slv_scl_low <= 1'b1;
    repeat (60) @(negedge clk);
    check_acks(0);
    assert (scl_dir == 1'b1) else begin
      $display("CHECK FAILED at %0t: scl_dir_o = %b, expected %b", $time, scl_dir, 1'b1);
      stim_errors++;
    end
    @(posedge clk);
    slv_scl_low <= 1'b0;
    wait_ack("stretched WRITE");
    check_acks(1);

    // write a 1 against a slave holding sda low
    issue_cmd(i2c_cmd_pkg::CMD_WRITE, 1'b1, 1'b1);
    wait_lost();
    @(posedge clk);
    cmd <= i2c_cmd_pkg::CMD_NOP;
    repeat (40) @(negedge clk);
    check_acks(0);
    assert ({scl_dir, sda_dir} == 2'b11) else begin
      $display("CHECK FAILED at %0t: {scl_dir_o,sda_dir_o} = %b, expected %b",
               $time, {scl_dir, sda_dir}, 2'b11);
      stim_errors++;
    end
    @(posedge clk);
    slv_sda_low <= 1'b0;  // bus goes idle
    repeat (20) @(posedge clk);

    $display("summary: %0d check errors, %0d timeouts", chk_errors + stim_errors, timeouts);
    if (chk_errors + stim_errors + timeouts == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: all.f
logic/i2c_bus_pkg.sv
logic/i2c_cmd_pkg.sv
logic/i2c_line_if.sv
logic/i2c_filter_tick.sv
logic/i2c_line_filter.sv
logic/i2c_bus_monitor.sv
logic/i2c_scl_timer.sv
logic/i2c_bit_fsm.sv
logic/i2c_bit_ctrl.sv
bench/tb_i2c_bit_ctrl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the i2c bit controller testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_i2c_bit_ctrl
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module "$TOP" --Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF '*** PASSED ***' "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
